//--- rtl/enc_defines.svh
/*
 * quadrature encoder block constants
 * channel count, register map fields, filter and period timing
 */
`ifndef ENC_DEFINES_SVH
`define ENC_DEFINES_SVH

// --------------------------------------------------
// register map
`define NUM_ENC         4               // encoder channels, numbered 1..4
`define ADDR_MAIN       4'h0            // reg_waddr[15:12] block select
`define OFF_ENC_LOAD    4'h0            // preload, write and read
`define OFF_ENC_DATA    4'h1            // {ovf, count}
`define OFF_PER_DATA    4'h2            // {dir, period ticks}

// --------------------------------------------------
// datapath
`define PRELOAD_RESET   24'h800000      // half scale
`define DEB_LEN         4               // stable run length for the line filter
`define PERD_DIV        16              // sysclk cycles per period tick
`define PERD_MAX        31'h7FFFFFFF    // period tick count saturates here

`endif

//--- rtl/enc_pkg.sv
/*
 * encoder subsystem types
 * shared by the channel datapath, the register decode and the bench
 */
package enc_pkg;

    // position as read back
    // bit 24  sticky overflow, set on wrap either way
    // 23..0   up/down count
    typedef logic [24:0] enc_count_t;

    // value copied into the counter on a load strobe
    typedef logic [23:0] enc_preload_t;

    // edge-to-edge period
    // bit 31  direction of the last edge, 1 = up
    // 30..0   tick count, saturating
    typedef logic [31:0] enc_period_t;

    // channel select, reg address bits 7..4
    // 1..NUM_ENC map to a channel, 0 and the rest read zero
    typedef logic [3:0] enc_chan_t;

    // register bus
    typedef logic [15:0] reg_addr_t;    // [15:12] block, [7:4] chan, [3:0] offset
    typedef logic [31:0] reg_data_t;    // narrower fields are zero-extended

endpackage

//--- rtl/enc_debounce.sv
/*
 * line filter for one raw encoder input
 * two-stage sync, then a run counter before the output follows
 */
`include "enc_defines.svh"

module enc_debounce (
    input  logic sysclk,
    input  logic reset,         // sync, active low
    input  logic din,           // raw line from the connector
    output logic dout           // filtered line
);

    // stage 2 already trails din by two samples, so the flip needs
    // DEB_LEN - 1 disagreeing samples there to land DEB_LEN + 1 after din
    localparam int RUN_LAST = `DEB_LEN - 2;
    localparam int RUN_W    = (`DEB_LEN > 2) ? $clog2(`DEB_LEN) : 1;

    logic [1:0]       sync_q;   // [0] first stage, [1] compared
    logic [RUN_W-1:0] run_cnt;  // consecutive disagreeing samples, minus one

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            sync_q  <= 2'b00;
            run_cnt <= '0;
            dout    <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[0], din};
            if (sync_q[1] == dout)
                run_cnt <= '0;                  // run broken, start over
            else if (run_cnt == RUN_W'(RUN_LAST))
            begin
                dout    <= sync_q[1];           // run complete, follow input
                run_cnt <= '0;
            end
            else
                run_cnt <= run_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/enc_quad.sv
/*
 * quadrature decoder with 24-bit up/down position counter
 * preload on strobe, sticky overflow on wrap, direction of last step
 */
`include "enc_defines.svh"

module enc_quad (
    input  logic                  sysclk,
    input  logic                  reset,     // sync, active low
    input  logic                  a,         // filtered A
    input  logic                  b,         // filtered B
    input  logic                  load,      // one-cycle preload strobe
    input  enc_pkg::enc_preload_t preload,
    output enc_pkg::enc_count_t   count,     // {ovf, position}
    output logic                  dir        // 1 = last step was up
);

    import enc_pkg::*;

    logic [1:0]   ab_prev;      // {a, b} at the previous edge
    logic [1:0]   ab_cur;
    logic         step;         // exactly one line moved
    logic         both;         // both lines moved, illegal
    logic         up;           // step direction
    enc_preload_t pos_q;
    logic         ovf_q;
    logic         dir_q;

    // --------------------------------------------------
    // step decode
    // up sequence {a,b}: 00 -> 10 -> 11 -> 01 -> 00 (A leads)
    assign ab_cur = {a, b};
    assign step   = ^(ab_prev ^ ab_cur);    // odd number of changes
    assign both   = &(ab_prev ^ ab_cur);
    assign up     = a ^ ab_prev[0];         // new A against old B

    // --------------------------------------------------
    // counter
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            ab_prev <= 2'b00;                   // filtered lines reset low
            pos_q   <= `PRELOAD_RESET;
            ovf_q   <= 1'b0;
            dir_q   <= 1'b0;
        end
        else
        begin
            ab_prev <= ab_cur;
            if (step)
                dir_q <= up;
            if (load)
            begin
                pos_q <= preload;               // load wins over a step
                ovf_q <= 1'b0;
            end
            else if (step)
            begin
                if (up)
                begin
                    if (pos_q == '1)
                        ovf_q <= 1'b1;          // wrap to zero
                    pos_q <= pos_q + 1'b1;
                end
                else
                begin
                    if (pos_q == '0)
                        ovf_q <= 1'b1;          // wrap to all ones
                    pos_q <= pos_q - 1'b1;
                end
            end
        end
    end

    assign count = {ovf_q, pos_q};
    assign dir   = dir_q;

    // a double change carries no direction, position must hold
    a_illegal_hold: assert property (@(posedge sysclk) disable iff (!reset)
        (both && !load) |=> $stable(count));

endmodule

//--- rtl/enc_period.sv
/*
 * edge-to-edge period meter for one encoder channel
 * counts slow ticks between A/B edges, latches count and direction
 */
`include "enc_defines.svh"

module enc_period (
    input  logic                 sysclk,
    input  logic                 reset,     // sync, active low
    input  logic                 a,         // filtered A
    input  logic                 b,         // filtered B
    input  logic                 dir,       // from the decoder, valid a cycle after edge
    output enc_pkg::enc_period_t period     // {dir, ticks}
);

    import enc_pkg::*;

    localparam int PRESC_W = (`PERD_DIV > 1) ? $clog2(`PERD_DIV) : 1;

    logic [PRESC_W-1:0] presc;      // sysclk cycles within one tick
    logic               tick;
    logic               a_q;
    logic               b_q;
    logic               edge_q;     // edge seen last cycle, dir now settled
    logic [30:0]        run_cnt;    // ticks since the last edge
    enc_period_t        perd_q;

    // --------------------------------------------------
    // tick prescaler, free running
    assign tick = (presc == PRESC_W'(`PERD_DIV - 1));

    always_ff @(posedge sysclk)
    begin
        if (!reset)
            presc <= '0;
        else if (tick)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    // --------------------------------------------------
    // edge detect
    // delayed one cycle so the decoder has updated dir for this edge
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            a_q    <= 1'b0;
            b_q    <= 1'b0;
            edge_q <= 1'b0;
        end
        else
        begin
            a_q    <= a;
            b_q    <= b;
            edge_q <= (a ^ a_q) | (b ^ b_q);    // any line, either way
        end
    end

    // --------------------------------------------------
    // running count and latch
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            run_cnt <= '0;
            perd_q  <= '0;
        end
        else if (edge_q)
        begin
            perd_q  <= {dir, run_cnt};
            run_cnt <= '0;                      // tick on this cycle dropped
        end
        else if (tick && run_cnt != `PERD_MAX)
            run_cnt <= run_cnt + 1'b1;          // stops at full scale
    end

    assign period = perd_q;

    // running count never passes PERD_MAX, it holds there until an edge
    a_run_sat: assert property (@(posedge sysclk) disable iff (!reset)
        (run_cnt == `PERD_MAX && !edge_q) |=> (run_cnt == `PERD_MAX));

endmodule

//--- rtl/enc_ctrl.sv
/*
 * encoder register file
 * preload writes with one-cycle load strobes, read mux over all channels
 */
`include "enc_defines.svh"

module enc_ctrl (
    input  logic                  sysclk,
    input  logic                  reset,                    // sync, active low
    input  logic                  reg_wen,                  // single-cycle write strobe
    input  enc_pkg::reg_addr_t    reg_raddr,
    input  enc_pkg::reg_addr_t    reg_waddr,
    input  enc_pkg::reg_data_t    reg_wdata,
    input  enc_pkg::enc_count_t   quad_data [1:`NUM_ENC],   // per channel {ovf, count}
    input  enc_pkg::enc_period_t  perd_data [1:`NUM_ENC],   // per channel {dir, ticks}
    output enc_pkg::enc_preload_t preload   [1:`NUM_ENC],
    output logic [1:`NUM_ENC]     set_enc,                  // load strobes
    output enc_pkg::reg_data_t    reg_rdata
);

    import enc_pkg::*;

    enc_chan_t  wr_chan;
    enc_chan_t  rd_chan;
    logic [3:0] rd_off;
    logic       wr_hit;     // preload write to a mapped channel

    // --------------------------------------------------
    // write decode
    assign wr_chan = enc_chan_t'(reg_waddr[7:4]);
    assign wr_hit  = reg_wen
                  && (reg_waddr[15:12] == `ADDR_MAIN)
                  && (reg_waddr[3:0] == `OFF_ENC_LOAD)
                  && (wr_chan != '0)
                  && (wr_chan <= `NUM_ENC);

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            set_enc <= '0;
            for (int i = 1; i <= `NUM_ENC; i++)
                preload[i] <= `PRELOAD_RESET;       // half scale
        end
        else
        begin
            for (int i = 1; i <= `NUM_ENC; i++)
            begin
                set_enc[i] <= wr_hit && (wr_chan == i);   // cleared next cycle
                if (wr_hit && (wr_chan == i))
                    preload[i] <= reg_wdata[23:0];  // upper bits dropped
            end
        end
    end

    // --------------------------------------------------
    // read mux, combinational from reg_raddr
    // block select bits are not decoded on reads
    assign rd_chan = enc_chan_t'(reg_raddr[7:4]);
    assign rd_off  = reg_raddr[3:0];

    always_comb
    begin
        reg_rdata = '0;                             // chan 0, 5..15 read zero
        for (int i = 1; i <= `NUM_ENC; i++)
        begin
            if (rd_chan == i)
            begin
                case (rd_off)
                    `OFF_ENC_LOAD: reg_rdata = reg_data_t'(preload[i]);
                    `OFF_ENC_DATA: reg_rdata = reg_data_t'(quad_data[i]);
                    `OFF_PER_DATA: reg_rdata = perd_data[i];
                    default:       reg_rdata = '0;  // unmapped offset
                endcase
            end
        end
    end

    // --------------------------------------------------
    // load strobes
    a_strobe_onehot: assert property (@(posedge sysclk) disable iff (!reset)
        $onehot0(set_enc));

    // a load pulse on any channel drops after one cycle
    a_strobe_single: assert property (@(posedge sysclk) disable iff (!reset)
        (set_enc != '0) |=> ((set_enc & $past(set_enc)) == '0));

endmodule

//--- rtl/enc_top.sv
/*
 * four-channel quadrature encoder subsystem
 * line filters, position counters and period meters behind enc_ctrl
 */
`include "enc_defines.svh"

module enc_top (
    input  logic               sysclk,
    input  logic               reset,           // sync, active low
    input  logic [1:`NUM_ENC]  enc_a,           // raw A lines
    input  logic [1:`NUM_ENC]  enc_b,           // raw B lines
    input  enc_pkg::reg_addr_t reg_raddr,
    input  enc_pkg::reg_addr_t reg_waddr,
    input  enc_pkg::reg_data_t reg_wdata,
    input  logic               reg_wen,
    output enc_pkg::reg_data_t reg_rdata
);

    import enc_pkg::*;

    logic [1:`NUM_ENC] enc_a_filt;              // filtered lines
    logic [1:`NUM_ENC] enc_b_filt;
    logic [1:`NUM_ENC] dir;                     // last step direction
    logic [1:`NUM_ENC] set_enc;                 // preload strobes
    enc_preload_t      preload   [1:`NUM_ENC];
    enc_count_t        quad_data [1:`NUM_ENC];
    enc_period_t       perd_data [1:`NUM_ENC];

    // --------------------------------------------------
    // per-channel datapath
    genvar ch;
    generate
        for (ch = 1; ch <= `NUM_ENC; ch++)
        begin : g_chan
            enc_debounce u_filt_a (.sysclk, .reset, .din(enc_a[ch]), .dout(enc_a_filt[ch]));
            enc_debounce u_filt_b (.sysclk, .reset, .din(enc_b[ch]), .dout(enc_b_filt[ch]));

            enc_quad u_quad (
                .sysclk, .reset,
                .a(enc_a_filt[ch]), .b(enc_b_filt[ch]),
                .load(set_enc[ch]), .preload(preload[ch]),
                .count(quad_data[ch]), .dir(dir[ch])
            );

            enc_period u_perd (
                .sysclk, .reset,
                .a(enc_a_filt[ch]), .b(enc_b_filt[ch]),
                .dir(dir[ch]), .period(perd_data[ch])
            );
        end
    endgenerate

    // --------------------------------------------------
    // register file
    enc_ctrl u_ctrl (
        .sysclk, .reset,
        .reg_wen, .reg_raddr, .reg_waddr, .reg_wdata,
        .quad_data, .perd_data,
        .preload, .set_enc,
        .reg_rdata
    );

endmodule

//--- bench/enc_top_tb.sv
/*
 * testbench for the four-channel encoder subsystem
 * Gray-code steps on the raw lines, register reads checked against a reference model
 */
`include "enc_defines.svh"

module enc_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import enc_pkg::*;

    localparam int unsigned RAND_SEED  = 32'h91cd_83eb;
    localparam int          SETTLE_MAX = 64;            // reads before a count wait gives up
    localparam int          HOLD_MIN   = `DEB_LEN + 3;  // shortest raw state hold, cycles

    logic              sysclk = 1'b0;
    logic              reset;
    logic [1:`NUM_ENC] enc_a;
    logic [1:`NUM_ENC] enc_b;
    reg_addr_t         reg_raddr;
    reg_addr_t         reg_waddr;
    reg_data_t         reg_wdata;
    logic              reg_wen;
    reg_data_t         reg_rdata;

    // reference model, per channel
    logic [1:0]   ab_state  [1:`NUM_ENC];   // raw {a, b} as driven
    enc_count_t   exp_count [1:`NUM_ENC];   // {ovf, position}
    enc_preload_t exp_pre   [1:`NUM_ENC];

    enc_top u_enc_top (
        .sysclk, .reset, .enc_a, .enc_b,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata
    );

    always #10 sysclk = ~sysclk;            // 20 ns period

    // --------------------------------------------------
    // reference functions
    // forward order 00 -> 10 -> 11 -> 01, A leads
    function automatic logic [1:0] gray_next(input logic [1:0] s, input logic up);
        logic [1:0] n;
        case (s)
            2'b00:   n = up ? 2'b10 : 2'b01;
            2'b10:   n = up ? 2'b11 : 2'b00;
            2'b11:   n = up ? 2'b01 : 2'b10;
            default: n = up ? 2'b00 : 2'b11;
        endcase
        return n;
    endfunction

    // one legal step, overflow sticks on a wrap either way
    function automatic enc_count_t count_after_step(input enc_count_t c, input logic up);
        logic         ovf;
        enc_preload_t pos;
        ovf = c[24];
        pos = c[23:0];
        if (up)
        begin
            if (pos == 24'hFFFFFF)
                ovf = 1'b1;
            pos = pos + 24'd1;
        end
        else
        begin
            if (pos == 24'h000000)
                ovf = 1'b1;
            pos = pos - 24'd1;
        end
        return {ovf, pos};
    endfunction

    function automatic enc_period_t period_for_hold(input int hold, input logic up);
        return {up, 31'(hold / `PERD_DIV)};     // nominal ticks per edge
    endfunction

    function automatic reg_addr_t reg_addr(input logic [3:0] blk, input int chan,
                                           input logic [3:0] off);
        return {blk, 4'h0, 4'(chan), off};
    endfunction

    // --------------------------------------------------
    // compare tasks
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input enc_count_t got, input enc_count_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_preload(input string name, input enc_preload_t got,
                                 input enc_preload_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    // direction exact, ticks within tol
    task automatic check_period(input string name, input enc_period_t got,
                                input enc_period_t exp, input int tol);
        int got_ticks;
        int exp_ticks;
        got_ticks = int'(got[30:0]);
        exp_ticks = int'(exp[30:0]);
        if ($isunknown(got) || got[31] !== exp[31]
            || got_ticks < exp_ticks - tol || got_ticks > exp_ticks + tol)
            stop_run($sformatf("Mismatch %s: got %h, expected %h within %0d ticks",
                               name, got, exp, tol));
    endtask

    // --------------------------------------------------
    // bus and line drivers, entered and left on a falling edge
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_raddr = addr;
        @(posedge sysclk);
        data = reg_rdata;                       // settled since the falling edge
        @(negedge sysclk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen   = 1'b0;                       // single-cycle strobe
    endtask

    task automatic step_chan(input int ch, input logic up, input int hold);
        ab_state[ch]  = gray_next(ab_state[ch], up);
        enc_a[ch]     = ab_state[ch][1];
        enc_b[ch]     = ab_state[ch][0];
        exp_count[ch] = count_after_step(exp_count[ch], up);
        repeat (hold) @(negedge sysclk);        // edge to edge spacing
    endtask

    // poll the count register until it matches the model
    task automatic wait_count(input int ch);
        reg_data_t rd;
        int        tries;
        tries = 0;
        read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_DATA), rd);
        while (rd[24:0] !== exp_count[ch])
        begin
            if (tries == SETTLE_MAX)
                stop_run($sformatf("Timeout: count of channel %0d did not settle", ch));
            tries++;
            read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_DATA), rd);
        end
    endtask

    task automatic check_all_channels;
        reg_data_t rd;
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_LOAD), rd);
            check_preload($sformatf("preload[%0d]", ch), rd[23:0], exp_pre[ch]);
            check_data($sformatf("preload[%0d] upper bits", ch), rd & 32'hFF00_0000, '0);
            read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_DATA), rd);
            check_count($sformatf("count[%0d]", ch), rd[24:0], exp_count[ch]);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    initial
    begin
        reg_data_t    rd;
        int           hold;
        logic         up;
        enc_preload_t val;

        void'($urandom(RAND_SEED));             // one seed for the whole run
        reset     = 1'b0;
        enc_a     = '0;
        enc_b     = '0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            ab_state[ch]  = 2'b00;
            exp_pre[ch]   = `PRELOAD_RESET;
            exp_count[ch] = {1'b0, `PRELOAD_RESET};
        end
        repeat (3) @(negedge sysclk);           // three rising edges in reset
        reset = 1'b1;
        @(negedge sysclk);

        // reset values, period exactly zero
        check_all_channels();
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_PER_DATA), rd);
            check_period($sformatf("period[%0d]", ch), rd, '0, 0);
        end

        // random walk per channel, the rest must hold
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            repeat (3 + $urandom % 6)
                step_chan(ch, 1'($urandom), HOLD_MIN + int'($urandom % 6));
            wait_count(ch);
            check_all_channels();
        end

        // preload writes
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            val = enc_preload_t'($urandom);
            write_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_LOAD), {8'h00, val});
            exp_pre[ch]   = val;
            exp_count[ch] = {1'b0, val};
            wait_count(ch);
        end
        check_all_channels();

        // wrong block, wrong offset, unmapped channels
        write_reg(reg_addr(4'h3, 2, `OFF_ENC_LOAD), 32'h00AB_CDEF);
        write_reg(reg_addr(`ADDR_MAIN, 3, `OFF_ENC_DATA), 32'h0012_3456);
        write_reg(reg_addr(`ADDR_MAIN, 0, `OFF_ENC_LOAD), 32'h0065_4321);
        write_reg(reg_addr(`ADDR_MAIN, 5, `OFF_ENC_LOAD), 32'h0011_1111);
        repeat (3) @(negedge sysclk);
        check_all_channels();

        // wrap up on channel 1, down on channel 2
        write_reg(reg_addr(`ADDR_MAIN, 1, `OFF_ENC_LOAD), 32'h00FF_FFFF);
        write_reg(reg_addr(`ADDR_MAIN, 2, `OFF_ENC_LOAD), 32'h0000_0000);
        exp_pre[1]   = 24'hFFFFFF;
        exp_count[1] = {1'b0, 24'hFFFFFF};
        exp_pre[2]   = 24'h000000;
        exp_count[2] = {1'b0, 24'h000000};
        wait_count(1);
        wait_count(2);
        step_chan(1, 1'b1, HOLD_MIN);
        step_chan(2, 1'b0, HOLD_MIN);
        wait_count(1);                          // {1, 000000}
        wait_count(2);                          // {1, ffffff}
        check_all_channels();
        for (int ch = 1; ch <= 2; ch++)         // a reload clears the flag
        begin
            val = enc_preload_t'($urandom);
            write_reg(reg_addr(`ADDR_MAIN, ch, `OFF_ENC_LOAD), {8'h00, val});
            exp_pre[ch]   = val;
            exp_count[ch] = {1'b0, val};
            wait_count(ch);
        end

        // period and direction, odd channels up
        for (int ch = 1; ch <= `NUM_ENC; ch++)
        begin
            hold = 80 + int'($urandom % 96);
            up   = 1'(ch % 2);
            repeat (3)
                step_chan(ch, up, hold);
            wait_count(ch);
            read_reg(reg_addr(`ADDR_MAIN, ch, `OFF_PER_DATA), rd);
            check_period($sformatf("period[%0d]", ch), rd, period_for_hold(hold, up), 1);
        end

        // unmapped channels and offsets read zero
        for (int c = 0; c < 16; c++)
        begin
            for (int off = 0; off < 16; off++)
            begin
                if (c == 0 || c > `NUM_ENC || off > `OFF_PER_DATA)
                begin
                    read_reg(reg_addr(`ADDR_MAIN, c, 4'(off)), rd);
                    check_data($sformatf("reg_rdata chan %0d off %0d", c, off), rd, '0);
                end
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- enc_top.f
+incdir+rtl
rtl/enc_pkg.sv
rtl/enc_debounce.sv
rtl/enc_quad.sv
rtl/enc_period.sv
rtl/enc_ctrl.sv
rtl/enc_top.sv
bench/enc_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the encoder testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=enc_top_sim

verilator --binary --timing --assert -Wno-fatal \
    -f enc_top.f --top-module enc_top_tb \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
fi

if grep -q "^Simulation passed$" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi
